// ==== trace_pkg.sv ====
/* shared types and constants for the pipeline retirement tracer.
   Imported by the tag pipe, the stage timing block and the interface. */

package trace_pkg;

    ////////////////////
    // data types
    ////////////////////

    // pc and instruction words of the traced cpu
    typedef logic [31:0] word_t;

    ////////////////////
    // pipeline shape
    ////////////////////

    // fetch, decode, execute, memory, write-back
    localparam int PIPE_DEPTH = 5;

    // slot index of each stage in the shadow arrays
    localparam int STG_FETCH  = 0;
    localparam int STG_DECODE = 1;
    localparam int STG_EXEC   = 2;
    localparam int STG_MEM    = 3;

    // write-back is always the last slot
    localparam int STG_WB     = PIPE_DEPTH - 1;

endpackage

// ==== wb_tag_if.sv ====
`timescale 1ns/1ps

/* write-back stage identity from the tag pipe to the retire recorder.
   The tag pipe drives source and the recorder reads sink. */

interface wb_tag_if #(
    parameter int SEQ_W = 16
) ();
    import trace_pkg::*;

    // instruction sitting in write-back this cycle
    logic             valid;
    logic [SEQ_W-1:0] seq;
    word_t            pc;
    word_t            instr;

    modport source (
        output valid, seq, pc, instr
    );

    modport sink (
        input valid, seq, pc, instr
    );

endinterface

// ==== instr_tag_pipe.sv ====
`timescale 1ns/1ps

/* shadow pipe of valid bits, sequence numbers, pc and instruction words.
   Follows the cpu stall and flush rules and counts flushed entries. */

module instr_tag_pipe #(
    parameter int SEQ_W   = 16,
    parameter int CYCLE_W = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  trace_pkg::word_t   fetch_pc,
    input  trace_pkg::word_t   fetch_instr,
    input  logic               stall,
    input  logic               flush,
    wb_tag_if.source           wb,
    output logic [CYCLE_W-1:0] flush_count
);
    import trace_pkg::*;

    logic                  hold;
    logic                  advance;
    logic                  accept;
    logic [1:0]            kill_cnt;
    logic [SEQ_W-1:0]      seq_next;
    logic [PIPE_DEPTH-1:0] valid_q;
    logic [SEQ_W-1:0]      seq_q   [PIPE_DEPTH];
    word_t                 pc_q    [PIPE_DEPTH];
    word_t                 instr_q [PIPE_DEPTH];

    // flush beats stall, stall freezes fetch and decode
    assign hold    = stall && !flush;
    assign advance = !stall && !flush;
    assign accept  = advance && fetch_valid;

    // occupants of fetch and decode lost on a flush edge
    assign kill_cnt = {1'b0, valid_q[STG_FETCH]} + {1'b0, valid_q[STG_DECODE]};

    ////////////////////
    // valid bits
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            // front slots hold on stall, empty on flush
            valid_q[STG_FETCH]  <= hold ? valid_q[STG_FETCH] : accept;
            valid_q[STG_DECODE] <= hold ? valid_q[STG_DECODE] : (advance && valid_q[STG_FETCH]);
            // bubble into execute unless decode moves on
            valid_q[STG_EXEC]   <= advance && valid_q[STG_DECODE];
            for (int s = STG_MEM; s < PIPE_DEPTH; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    ////////////////////
    // identity payload
    ////////////////////

    always_ff @(posedge clk) begin
        if (!hold) begin
            seq_q[STG_DECODE]   <= seq_q[STG_FETCH];
            pc_q[STG_DECODE]    <= pc_q[STG_FETCH];
            instr_q[STG_DECODE] <= instr_q[STG_FETCH];
            if (accept) begin
                seq_q[STG_FETCH]   <= seq_next;
                pc_q[STG_FETCH]    <= fetch_pc;
                instr_q[STG_FETCH] <= fetch_instr;
            end
        end
        // back half always shifts, validity decides what counts
        for (int s = STG_EXEC; s < PIPE_DEPTH; s++) begin
            seq_q[s]   <= seq_q[s-1];
            pc_q[s]    <= pc_q[s-1];
            instr_q[s] <= instr_q[s-1];
        end
    end

    // next sequence number, wraps at SEQ_W
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_next <= '0;
        end else if (accept) begin
            seq_next <= seq_next + 1'b1;
        end
    end

    // killed instruction counter
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (flush) begin
            flush_count <= flush_count + CYCLE_W'(kill_cnt);
        end
    end

    // write-back slot out to the recorder
    assign wb.valid = valid_q[STG_WB];
    assign wb.seq   = seq_q[STG_WB];
    assign wb.pc    = pc_q[STG_WB];
    assign wb.instr = instr_q[STG_WB];

endmodule

// ==== stage_timing.sv ====
`timescale 1ns/1ps

/* cycle counter plus a shadow pipe of fetch timestamps and stall counts.
   Shifts in step with the tag pipe. Empty slots carry don't-care values. */

module stage_timing #(
    parameter int CYCLE_W = 32,
    parameter int STALL_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  logic               stall,
    input  logic               flush,
    output logic [CYCLE_W-1:0] wb_fetch_cycle,
    output logic [STALL_W-1:0] wb_stall_cycles
);
    import trace_pkg::*;

    localparam logic [STALL_W-1:0] STALL_MAX = '1;

    logic               hold;
    logic               accept;
    logic [CYCLE_W-1:0] cycle_cnt;
    logic [CYCLE_W-1:0] stamp_q [PIPE_DEPTH];
    logic [STALL_W-1:0] stalls_q [PIPE_DEPTH];

    // same movement decode as the tag pipe
    assign hold   = stall && !flush;
    assign accept = !stall && !flush && fetch_valid;

    ////////////////////
    // free-running cycle counter
    ////////////////////

    // reads 0 at the first edge out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    ////////////////////
    // timestamp and stall shadow
    ////////////////////

    always_ff @(posedge clk) begin
        if (hold) begin
            // held slots collect one stall each, saturating
            for (int s = STG_FETCH; s <= STG_DECODE; s++) begin
                if (stalls_q[s] != STALL_MAX) begin
                    stalls_q[s] <= stalls_q[s] + 1'b1;
                end
            end
        end else begin
            stamp_q[STG_DECODE]  <= stamp_q[STG_FETCH];
            stalls_q[STG_DECODE] <= stalls_q[STG_FETCH];
            if (accept) begin
                stamp_q[STG_FETCH]  <= cycle_cnt;
                stalls_q[STG_FETCH] <= '0;
            end
        end
        for (int s = STG_EXEC; s < PIPE_DEPTH; s++) begin
            stamp_q[s]  <= stamp_q[s-1];
            stalls_q[s] <= stalls_q[s-1];
        end
    end

    assign wb_fetch_cycle  = stamp_q[STG_WB];
    assign wb_stall_cycles = stalls_q[STG_WB];

endmodule

// ==== retire_recorder.sv ====
`timescale 1ns/1ps

/* joins write-back identity and timing into one registered trace record.
   trace_valid pulses one cycle per retired instruction. */

module retire_recorder #(
    parameter int SEQ_W   = 16,
    parameter int CYCLE_W = 32,
    parameter int STALL_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    wb_tag_if.sink             wb,
    input  logic [CYCLE_W-1:0] wb_fetch_cycle,
    input  logic [STALL_W-1:0] wb_stall_cycles,
    output logic               trace_valid,
    output logic [SEQ_W-1:0]   trace_seq,
    output trace_pkg::word_t   trace_pc,
    output trace_pkg::word_t   trace_instr,
    output logic [CYCLE_W-1:0] trace_fetch_cycle,
    output logic [STALL_W-1:0] trace_stall_cycles,
    output logic [CYCLE_W-1:0] retire_count
);

    ////////////////////
    // strobe and counter
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid  <= 1'b0;
            retire_count <= '0;
        end else begin
            trace_valid <= wb.valid;
            if (wb.valid) begin
                retire_count <= retire_count + 1'b1;
            end
        end
    end

    // record fields, held between strobes
    always_ff @(posedge clk) begin
        if (wb.valid) begin
            trace_seq          <= wb.seq;
            trace_pc           <= wb.pc;
            trace_instr        <= wb.instr;
            // timing side lines up with the same slot
            trace_fetch_cycle  <= wb_fetch_cycle;
            trace_stall_cycles <= wb_stall_cycles;
        end
    end

endmodule

// ==== pipe_tracer_top.sv ====
`timescale 1ns/1ps

/* top level of the retirement tracer. Hook the cpu strobes to the inputs
   and take one trace record per trace_valid pulse. */

module pipe_tracer_top #(
    parameter int SEQ_W   = 16,
    parameter int CYCLE_W = 32,
    parameter int STALL_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,
    input  trace_pkg::word_t   fetch_pc,
    input  trace_pkg::word_t   fetch_instr,
    input  logic               stall,
    input  logic               flush,
    output logic               trace_valid,
    output logic [SEQ_W-1:0]   trace_seq,
    output trace_pkg::word_t   trace_pc,
    output trace_pkg::word_t   trace_instr,
    output logic [CYCLE_W-1:0] trace_fetch_cycle,
    output logic [STALL_W-1:0] trace_stall_cycles,
    output logic [CYCLE_W-1:0] retire_count,
    output logic [CYCLE_W-1:0] flush_count
);

    // timing results of the write-back slot
    logic [CYCLE_W-1:0] wb_fetch_cycle;
    logic [STALL_W-1:0] wb_stall_cycles;

    wb_tag_if #(.SEQ_W(SEQ_W)) wb_tag ();

    // identity side
    instr_tag_pipe #(
        .SEQ_W   (SEQ_W),
        .CYCLE_W (CYCLE_W)
    ) u_tag_pipe (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .flush       (flush),
        .wb          (wb_tag.source),
        .flush_count (flush_count)
    );

    // timing side, runs in lockstep
    stage_timing #(
        .CYCLE_W (CYCLE_W),
        .STALL_W (STALL_W)
    ) u_stage_timing (
        .clk             (clk),
        .rst             (rst),
        .fetch_valid     (fetch_valid),
        .stall           (stall),
        .flush           (flush),
        .wb_fetch_cycle  (wb_fetch_cycle),
        .wb_stall_cycles (wb_stall_cycles)
    );

    retire_recorder #(
        .SEQ_W   (SEQ_W),
        .CYCLE_W (CYCLE_W),
        .STALL_W (STALL_W)
    ) u_recorder (
        .clk                (clk),
        .rst                (rst),
        .wb                 (wb_tag.sink),
        .wb_fetch_cycle     (wb_fetch_cycle),
        .wb_stall_cycles    (wb_stall_cycles),
        .trace_valid        (trace_valid),
        .trace_seq          (trace_seq),
        .trace_pc           (trace_pc),
        .trace_instr        (trace_instr),
        .trace_fetch_cycle  (trace_fetch_cycle),
        .trace_stall_cycles (trace_stall_cycles),
        .retire_count       (retire_count)
    );

endmodule

// ==== pipe_tracer_assert.sv ====
`timescale 1ns/1ps

/* concurrent checks on the tracer outputs, bound into the top level. */

module pipe_tracer_assert #(
    parameter int SEQ_W   = 16,
    parameter int CYCLE_W = 32
) (
    input logic               clk,
    input logic               rst,
    input logic               trace_valid,
    input logic [SEQ_W-1:0]   trace_seq,
    input logic [CYCLE_W-1:0] retire_count,
    input logic [CYCLE_W-1:0] flush_count
);
    import trace_pkg::*;

    logic [CYCLE_W-1:0] fc_hist [PIPE_DEPTH-1];
    logic [CYCLE_W-1:0] fc_mark;
    logic [CYCLE_W-1:0] prev_retire;
    logic [SEQ_W-1:0]   last_seq;
    logic [SEQ_W-1:0]   seq_step;
    logic               seen_one;

    assign seq_step = trace_seq - last_seq;

    // flush_count history reaches back to when the retiring entry left decode
    always_ff @(posedge clk) begin
        fc_hist[0] <= flush_count;
        for (int i = 1; i < PIPE_DEPTH - 1; i++) begin
            fc_hist[i] <= fc_hist[i-1];
        end
        prev_retire <= retire_count;
        if (rst) begin
            seen_one <= 1'b0;
        end else if (trace_valid) begin
            seen_one <= 1'b1;
            last_seq <= trace_seq;
            fc_mark  <= fc_hist[PIPE_DEPTH-2];
        end
    end

    // no record right after a reset edge
    a_quiet_in_reset: assert property (@(posedge clk) rst |=> !trace_valid)
        else $error("trace_valid high while in reset");

    a_retire_step: assert property (@(posedge clk) disable iff (rst)
        retire_count == prev_retire + CYCLE_W'(trace_valid))
        else $error("retire_count out of step with trace_valid");

    // a gap in seq only where a flush killed entries
    a_seq_order: assert property (@(posedge clk) disable iff (rst)
        (trace_valid && seen_one) |->
            ((seq_step == SEQ_W'(1)) || (flush_count != fc_mark && seq_step != '0)))
        else $error("trace_seq did not advance as expected");

endmodule

bind pipe_tracer_top pipe_tracer_assert #(
    .SEQ_W   (SEQ_W),
    .CYCLE_W (CYCLE_W)
) u_assert (
    .clk          (clk),
    .rst          (rst),
    .trace_valid  (trace_valid),
    .trace_seq    (trace_seq),
    .retire_count (retire_count),
    .flush_count  (flush_count)
);

// ==== tb_pipe_tracer.sv ====
`timescale 1ns/1ps

/* testbench for the retirement tracer. Applies a table of fetch, stall and flush
   patterns and checks every trace record against a model of the stage rules. */

module tb_pipe_tracer;
    import trace_pkg::*;

    localparam int SEQ_W   = 16;
    localparam int CYCLE_W = 32;
    localparam int STALL_W = 8;
    localparam int N_ROWS  = 18;
    localparam logic [STALL_W-1:0] STALL_MAX = '1;

    // one table row is a level pattern held for reps cycles
    typedef struct packed {
        logic       fetch_valid;
        logic       stall;
        logic       flush;
        logic [9:0] reps;
    } row_t;

    // expected trace record
    typedef struct packed {
        logic [SEQ_W-1:0]   seq;
        word_t              pc;
        word_t              instr;
        logic [CYCLE_W-1:0] stamp;
        logic [STALL_W-1:0] stalls;
    } rec_t;

    logic               clk;
    logic               rst;
    logic               fetch_valid;
    word_t              fetch_pc;
    word_t              fetch_instr;
    logic               stall;
    logic               flush;
    logic               trace_valid;
    logic [SEQ_W-1:0]   trace_seq;
    word_t              trace_pc;
    word_t              trace_instr;
    logic [CYCLE_W-1:0] trace_fetch_cycle;
    logic [STALL_W-1:0] trace_stall_cycles;
    logic [CYCLE_W-1:0] retire_count;
    logic [CYCLE_W-1:0] flush_count;

    row_t               rows [N_ROWS];
    rec_t               exp_q [$];
    // model of the fetch and decode slots
    rec_t               f_rec;
    rec_t               d_rec;
    logic               f_v;
    logic               d_v;
    logic [SEQ_W-1:0]   seq_ctr;
    logic [CYCLE_W-1:0] cyc;
    logic [CYCLE_W-1:0] exp_flush;
    logic [CYCLE_W-1:0] exp_retire;
    logic [31:0]        lcg_state;
    int                 value_errors;
    int                 other_errors;
    int                 total_cycles;
    int                 run_cycles;

    pipe_tracer_top #(
        .SEQ_W   (SEQ_W),
        .CYCLE_W (CYCLE_W),
        .STALL_W (STALL_W)
    ) i_dut (
        .clk                (clk),
        .rst                (rst),
        .fetch_valid        (fetch_valid),
        .fetch_pc           (fetch_pc),
        .fetch_instr        (fetch_instr),
        .stall              (stall),
        .flush              (flush),
        .trace_valid        (trace_valid),
        .trace_seq          (trace_seq),
        .trace_pc           (trace_pc),
        .trace_instr        (trace_instr),
        .trace_fetch_cycle  (trace_fetch_cycle),
        .trace_stall_cycles (trace_stall_cycles),
        .retire_count       (retire_count),
        .flush_count        (flush_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            value_errors++;
            $display("** Error: %s is %h, expected %h at %0t", name, got, want, $time);
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // one rising edge of the stage rules, on the inputs seen at that edge
    task automatic model_edge();
        if (flush) begin
            // flush wins, front occupants are lost
            exp_flush = exp_flush + CYCLE_W'(f_v) + CYCLE_W'(d_v);
            f_v = 1'b0;
            d_v = 1'b0;
        end else if (stall) begin
            if (f_v && f_rec.stalls != STALL_MAX) begin
                f_rec.stalls = f_rec.stalls + 1'b1;
            end
            if (d_v && d_rec.stalls != STALL_MAX) begin
                d_rec.stalls = d_rec.stalls + 1'b1;
            end
        end else begin
            // leaving decode means it will retire
            if (d_v) begin
                exp_q.push_back(d_rec);
                exp_retire = exp_retire + 1'b1;
            end
            d_v   = f_v;
            d_rec = f_rec;
            f_v   = fetch_valid;
            if (fetch_valid) begin
                f_rec = '{seq: seq_ctr, pc: fetch_pc, instr: fetch_instr, stamp: cyc,
                          stalls: '0};
                seq_ctr = seq_ctr + 1'b1;
            end
        end
    endtask

    task automatic check_record();
        rec_t want;
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("trace record with seq %h arrived but nothing was due to retire",
                     trace_seq);
        end else begin
            want = exp_q.pop_front();
            check_value("trace_seq", 32'(trace_seq), 32'(want.seq));
            check_value("trace_pc", trace_pc, want.pc);
            check_value("trace_instr", trace_instr, want.instr);
            check_value("trace_fetch_cycle", trace_fetch_cycle, want.stamp);
            check_value("trace_stall_cycles", 32'(trace_stall_cycles), 32'(want.stalls));
        end
    endtask

    // sample 1 ns after the edge, inputs still hold the values of that edge
    always @(posedge clk) begin
        #1;
        if (rst) begin
            f_v       = 1'b0;
            d_v       = 1'b0;
            seq_ctr   = '0;
            cyc       = '0;
            exp_flush = '0;
        end else begin
            model_edge();
            cyc = cyc + 1'b1;
        end
        if (trace_valid) begin
            check_record();
        end
        check_value("flush_count", flush_count, exp_flush);
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic drive_cycle(input logic fv, input logic st, input logic fl);
        @(posedge clk);
        #2;
        fetch_valid = fv;
        stall       = st;
        flush       = fl;
        fetch_pc    = lcg_next();
        fetch_instr = lcg_next();
    endtask

    initial begin
        rows = '{
            '{1'b1, 1'b0, 1'b0, 10'd12},   // back-to-back stream
            '{1'b1, 1'b1, 1'b0, 10'd3},    // stall mid stream
            '{1'b1, 1'b0, 1'b0, 10'd2},
            '{1'b0, 1'b1, 1'b0, 10'd2},
            '{1'b1, 1'b0, 1'b0, 10'd6},
            '{1'b1, 1'b0, 1'b1, 10'd1},    // flush with full front
            '{1'b1, 1'b0, 1'b0, 10'd5},
            '{1'b0, 1'b0, 1'b0, 10'd4},    // gaps
            '{1'b1, 1'b0, 1'b0, 10'd1},
            '{1'b0, 1'b0, 1'b0, 10'd3},
            '{1'b0, 1'b0, 1'b1, 10'd1},    // flush of an empty front
            '{1'b1, 1'b0, 1'b0, 10'd3},
            '{1'b1, 1'b1, 1'b1, 10'd1},    // stall and flush together
            '{1'b1, 1'b0, 1'b0, 10'd4},
            '{1'b1, 1'b1, 1'b0, 10'd260},  // long enough to saturate
            '{1'b0, 1'b0, 1'b0, 10'd2},
            '{1'b1, 1'b0, 1'b0, 10'd1},
            '{1'b0, 1'b0, 1'b1, 10'd1}
        };
        lcg_state    = 32'hfa82;
        value_errors = 0;
        other_errors = 0;
        exp_retire   = '0;
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        foreach (rows[i]) begin
            total_cycles += int'(rows[i].reps);
        end
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i]) begin
            repeat (rows[i].reps) begin
                drive_cycle(rows[i].fetch_valid, rows[i].stall, rows[i].flush);
            end
        end
        // drain until the model has nothing left in flight
        drive_cycle(1'b0, 1'b0, 1'b0);
        while (exp_q.size() != 0 || f_v || d_v) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
        end
        // a few idle cycles to catch stray strobes
        repeat (4) drive_cycle(1'b0, 1'b0, 1'b0);
        check_value("retire_count", retire_count, exp_retire);
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog, counts cycles out of reset
    initial begin
        run_cycles = 0;
        wait (total_cycles > 0);
        while (run_cycles <= total_cycles + 50) begin
            @(posedge clk);
            if (!rst) begin
                run_cycles++;
            end
        end
        $display("timeout: the pipe did not drain within %0d cycles", total_cycles + 50);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== pipe_tracer_top.f ====
trace_pkg.sv
wb_tag_if.sv
instr_tag_pipe.sv
stage_timing.sv
retire_recorder.sv
pipe_tracer_top.sv
pipe_tracer_assert.sv
tb_pipe_tracer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the tracer testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pipe_tracer \
    -f pipe_tracer_top.f \
    -Mdir "$obj" -o sim_tracer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$obj/sim_tracer" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
